// ==== hdl/mipsfpga_pkg.sv ====
/*
 * Shared definitions for the dual-master AHB-Lite subsystem:
 * bus structs, transfer encodings, memory map and I/O register offsets.
 */
`default_nettype none

package mipsfpga_pkg;

	// ********************************************************
	// Transfer encodings

	typedef enum logic [1:0] {
		IDLE   = 2'b00,                         // No transfer
		BUSY   = 2'b01,                         // Burst pause, unused here
		NONSEQ = 2'b10,                         // Single or first beat
		SEQ    = 2'b11                          // Treated like NONSEQ
	} htrans_t;

	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

	// ********************************************************
	// Bus structs

	typedef struct packed {
		logic [31:0] haddr;                     // Address phase
		htrans_t     htrans;
		logic        hwrite;
		hsize_t      hsize;
		logic [31:0] hwdata;                    // Data phase
	} ahb_req_t;

	typedef struct packed {
		logic [31:0] hrdata;
		logic        hready;                    // Low stalls the bus
		logic        hresp;                     // 1 is ERROR
	} ahb_resp_t;

	typedef enum logic [1:0] {
		SEL_RAM,
		SEL_GPIO,
		SEL_NONE                                // Unmapped, answered with ERROR
	} slave_sel_t;

	// ********************************************************
	// Memory map

	localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
	localparam logic [31:0] GPIO_BASE = 32'h1F80_0000;
	localparam logic [31:0] GPIO_SPAN = 32'h0000_0040;  // Size of the register window
	localparam int          GPIO_OFS_W = 6;             // Offset bits inside the window

	// I/O register offsets
	localparam logic [GPIO_OFS_W-1:0] LEDR_OFS    = 6'h00;
	localparam logic [GPIO_OFS_W-1:0] LEDG_OFS    = 6'h04;
	localparam logic [GPIO_OFS_W-1:0] SWITCH_OFS  = 6'h08;
	localparam logic [GPIO_OFS_W-1:0] PB_OFS      = 6'h0C;
	localparam logic [GPIO_OFS_W-1:0] SCRATCH_OFS = 6'h20;  // SCRATCH0, up to 6'h3C

	// I/O widths
	localparam int LEDR_W      = 18;
	localparam int LEDG_W      = 9;
	localparam int SW_W        = 18;
	localparam int PB_W        = 5;
	localparam int NUM_SCRATCH = 8;

endpackage

`default_nettype wire

// ==== hdl/ejtag_reset.sv ====
/*
 * EJTAG reset generator. Holds the reset for TRST_CYCLES clocks after
 * power-up, then passes the probe reset through.
 */
`default_nettype none

module ejtag_reset #(
	parameter int TRST_CYCLES = 16
) (
	input  wire   si_clk_in,
	input  wire   arst_n,
	input  wire   ej_trst_n_probe,                  // Active low from the probe
	output logic  ej_trst_n
);

	localparam int CW = $clog2(TRST_CYCLES + 1);

	logic [CW-1:0] cnt_q;                           // Saturates at TRST_CYCLES
	logic          released;

	assign released = (cnt_q == CW'(TRST_CYCLES));

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q <= '0;
		end else if (!released) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign ej_trst_n = released & ej_trst_n_probe;  // Either side can hold reset

endmodule

`default_nettype wire

// ==== hdl/ahb_arbiter.sv ====
/*
 * Two-master round-robin arbiter driven by request and grant levels.
 * Ownership moves only on an idle bus edge with hready high.
 */
`default_nettype none

module ahb_arbiter import mipsfpga_pkg::*; (
	input  wire            si_clk_in,
	input  wire            arst_n,
	input  wire [1:0]      busreq,                  // One level per master
	input  wire ahb_req_t  bus_req,                 // Muxed request of the owner
	input  wire            hready,
	output logic [1:0]     grant,
	output logic [1:0]     hmaster
);

	logic owner_q;                                  // 0 is m0, 1 is m1
	logic owner_d;
	logic handover_ok;

	// Owner has finished and nothing is stalled
	assign handover_ok = hready && (bus_req.htrans == IDLE);

	always_comb begin
		owner_d = owner_q;                          // Default keep
		if (handover_ok) begin
			case (busreq)
				2'b01:   owner_d = 1'b0;
				2'b10:   owner_d = 1'b1;
				2'b11:   owner_d = ~owner_q;        // Both want it, round robin
				default: owner_d = owner_q;         // Nobody asks, park on owner
			endcase
		end
	end

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			owner_q <= 1'b0;                        // m0 owns after reset
		end else begin
			owner_q <= owner_d;
		end
	end

	// Grant and hmaster come from the same flop, so they move together
	assign grant   = owner_q ? 2'b10 : 2'b01;
	assign hmaster = {1'b0, owner_q};

endmodule

`default_nettype wire

// ==== hdl/ahb_master_mux.sv ====
/*
 * Master-side multiplexer. Address fields follow the current owner,
 * write data follows the owner of the data phase.
 */
`default_nettype none

module ahb_master_mux import mipsfpga_pkg::*; (
	input  wire            si_clk_in,
	input  wire            arst_n,
	input  wire ahb_req_t  m0_req,
	input  wire ahb_req_t  m1_req,
	input  wire [1:0]      hmaster,                 // Address-phase owner
	input  wire            hready,
	output ahb_req_t       bus_req
);

	logic addr_m1;                                  // m1 owns the address phase
	logic data_m1_q;                                // m1 owns the data phase

	assign addr_m1 = (hmaster == 2'd1);

	// Data phase owner moves one accepted cycle after the address owner
	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			data_m1_q <= 1'b0;
		end else if (hready) begin
			data_m1_q <= addr_m1;
		end
	end

	always_comb begin
		bus_req = addr_m1 ? m1_req : m0_req;        // Address, control
		// Write data of the transfer in flight, safe across a handover
		bus_req.hwdata = data_m1_q ? m1_req.hwdata : m0_req.hwdata;
	end

endmodule

`default_nettype wire

// ==== hdl/ahb_slave_mux.sv ====
/*
 * Address decoder and response multiplexer. Unmapped transfers get the
 * two-cycle ERROR response generated here.
 */
`default_nettype none

module ahb_slave_mux import mipsfpga_pkg::*; #(
	parameter int RAM_WORDS = 1024
) (
	input  wire             si_clk_in,
	input  wire             arst_n,
	input  wire ahb_req_t   bus_req,
	input  wire ahb_resp_t  ram_resp,
	input  wire ahb_resp_t  gpio_resp,
	output logic            ram_sel,
	output logic            gpio_sel,
	output ahb_resp_t       resp
);

	localparam logic [31:0] RAM_SPAN = RAM_WORDS * 4;   // Bytes

	slave_sel_t target;                             // Address-phase decode
	slave_sel_t dsel_q;                             // Data-phase target
	logic       dvalid_q;                           // Data phase carries a transfer
	logic       err_q;                              // Second ERROR cycle
	logic       active;

	assign active = (bus_req.htrans == NONSEQ) || (bus_req.htrans == SEQ);

	always_comb begin
		if ((bus_req.haddr - RAM_BASE) < RAM_SPAN) begin
			target = SEL_RAM;
		end else if ((bus_req.haddr - GPIO_BASE) < GPIO_SPAN) begin
			target = SEL_GPIO;
		end else begin
			target = SEL_NONE;
		end
	end

	assign ram_sel  = active && (target == SEL_RAM);
	assign gpio_sel = active && (target == SEL_GPIO);

	// ********************************************************
	// Data phase tracking

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			dvalid_q <= 1'b0;
			dsel_q   <= SEL_NONE;
			err_q    <= 1'b0;
		end else begin
			if (resp.hready) begin                  // Next address phase accepted
				dvalid_q <= active;
				dsel_q   <= target;
			end
			// First ERROR cycle is followed by exactly one completing cycle
			err_q <= dvalid_q && (dsel_q == SEL_NONE) && !err_q;
		end
	end

	always_comb begin
		resp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};    // Idle data phase, OKAY
		if (dvalid_q) begin
			case (dsel_q)
				SEL_RAM:  resp = ram_resp;
				SEL_GPIO: resp = gpio_resp;
				default: begin
					resp.hready = err_q;            // Low first, then high
					resp.hresp  = 1'b1;             // ERROR on both cycles
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ahb_ram.sv ====
/*
 * Zero-wait AHB RAM of 32-bit words.
 * Byte and halfword writes use big-endian lanes: offset 0 is bits 31:24.
 */
`default_nettype none

module ahb_ram import mipsfpga_pkg::*; #(
	parameter int RAM_WORDS = 1024
) (
	input  wire            si_clk_in,
	input  wire            arst_n,
	input  wire ahb_req_t  bus_req,
	input  wire            ram_sel,
	input  wire            hready,
	output ahb_resp_t      ram_resp
);

	localparam int AW = $clog2(RAM_WORDS);          // Word index bits

	logic [31:0]   mem [RAM_WORDS];
	logic [AW-1:0] addr_q;                          // Word index of the data phase
	logic [1:0]    ofs_q;                           // Byte offset in the word
	hsize_t        size_q;
	logic          wr_q;                            // Data phase is a write
	logic [3:0]    be;                              // be[3] is bits 31:24

	// ********************************************************
	// Address phase

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			wr_q <= 1'b0;
		end else if (hready) begin
			wr_q <= ram_sel && bus_req.hwrite;
		end
	end

	always_ff @(posedge si_clk_in) begin
		if (hready && ram_sel) begin
			addr_q <= bus_req.haddr[AW+1:2];
			ofs_q  <= bus_req.haddr[1:0];
			size_q <= bus_req.hsize;
		end
	end

	// ********************************************************
	// Data phase

	always_comb begin
		case (size_q)
			BYTE:    be = 4'b1000 >> ofs_q;               // Offset 0 is MSB lane
			HALF:    be = ofs_q[1] ? 4'b0011 : 4'b1100;   // Offset 0 is upper half
			default: be = 4'b1111;
		endcase
	end

	always_ff @(posedge si_clk_in) begin
		if (wr_q && hready) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) begin
					mem[addr_q][8*i +: 8] <= bus_req.hwdata[8*i +: 8];
				end
			end
		end
	end

	// Whole word back, no wait states
	assign ram_resp = '{hrdata: mem[addr_q], hready: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

// ==== hdl/ahb_gpio.sv ====
/*
 * I/O slave with red and green LEDs, switches, push buttons and
 * scratch registers. Word writes only, zero wait states.
 */
`default_nettype none

module ahb_gpio import mipsfpga_pkg::*; (
	input  wire                          si_clk_in,
	input  wire                          arst_n,
	input  wire ahb_req_t                bus_req,
	input  wire                          gpio_sel,
	input  wire                          hready,
	input  wire [SW_W-1:0]               io_switch,     // Asynchronous
	input  wire [PB_W-1:0]               io_pb,         // Asynchronous
	output ahb_resp_t                    gpio_resp,
	output logic [LEDR_W-1:0]            io_ledr,
	output logic [LEDG_W-1:0]            io_ledg,
	output logic [NUM_SCRATCH-1:0][31:0] io_scratch
);

	localparam int SIW = $clog2(NUM_SCRATCH);       // Scratch index bits

	logic [GPIO_OFS_W-1:0] ofs_q;                   // Word-aligned register offset
	logic                  wr_q;
	logic [SW_W-1:0]       sw_meta;
	logic [SW_W-1:0]       sw_sync;
	logic [PB_W-1:0]       pb_meta;
	logic [PB_W-1:0]       pb_sync;
	logic                  scratch_hit;
	logic [SIW-1:0]        scratch_idx;
	logic [31:0]           rdata;

	// Two-flop synchronizers
	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			pb_meta <= '0;
			pb_sync <= '0;
		end else begin
			sw_meta <= io_switch;
			sw_sync <= sw_meta;
			pb_meta <= io_pb;
			pb_sync <= pb_meta;
		end
	end

	// ********************************************************
	// Address phase

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			wr_q <= 1'b0;
		end else if (hready) begin
			wr_q <= gpio_sel && bus_req.hwrite;
		end
	end

	always_ff @(posedge si_clk_in) begin
		if (hready && gpio_sel) begin
			ofs_q <= {bus_req.haddr[GPIO_OFS_W-1:2], 2'b00};   // Byte lanes ignored
		end
	end

	assign scratch_hit = (ofs_q >= SCRATCH_OFS);   // Top half of the window
	assign scratch_idx = ofs_q[2 +: SIW];

	// ********************************************************
	// Data phase

	always_ff @(posedge si_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			io_ledr    <= '0;
			io_ledg    <= '0;
			io_scratch <= '0;
		end else if (wr_q && hready) begin
			if (ofs_q == LEDR_OFS) begin
				io_ledr <= bus_req.hwdata[LEDR_W-1:0];
			end else if (ofs_q == LEDG_OFS) begin
				io_ledg <= bus_req.hwdata[LEDG_W-1:0];
			end else if (scratch_hit) begin
				io_scratch[scratch_idx] <= bus_req.hwdata;
			end
			// SWITCH and PB are read only
		end
	end

	always_comb begin
		rdata = '0;                                 // Unknown offsets read zero
		if (ofs_q == LEDR_OFS) begin
			rdata[LEDR_W-1:0] = io_ledr;
		end else if (ofs_q == LEDG_OFS) begin
			rdata[LEDG_W-1:0] = io_ledg;
		end else if (ofs_q == SWITCH_OFS) begin
			rdata[SW_W-1:0] = sw_sync;
		end else if (ofs_q == PB_OFS) begin
			rdata[PB_W-1:0] = pb_sync;
		end else if (scratch_hit) begin
			rdata = io_scratch[scratch_idx];
		end
	end

	assign gpio_resp = '{hrdata: rdata, hready: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

// ==== hdl/mipsfpga_sys.sv ====
/*
 * Dual-master AHB-Lite subsystem top level.
 * Wires the arbiter, master and slave muxes, RAM, I/O slave and the
 * EJTAG reset generator. The current bus owner is exported as core_id.
 */
`default_nettype none

module mipsfpga_sys import mipsfpga_pkg::*; #(
	parameter int RAM_WORDS   = 1024,               // RAM depth in 32-bit words
	parameter int TRST_CYCLES = 16                  // EJTAG reset pulse length
) (
	input  wire                          si_clk_in,
	input  wire                          arst_n,
	input  wire ahb_req_t                m0_req,    // Master 0 bus port
	input  wire ahb_req_t                m1_req,    // Master 1 bus port
	input  wire [1:0]                    busreq,
	input  wire [SW_W-1:0]               io_switch,
	input  wire [PB_W-1:0]               io_pb,
	input  wire                          ej_trst_n_probe,
	output logic [1:0]                   grant,
	output ahb_resp_t                    resp,      // Shared by both masters
	output logic [1:0]                   core_id,
	output logic [LEDR_W-1:0]            io_ledr,
	output logic [LEDG_W-1:0]            io_ledg,
	output logic [NUM_SCRATCH-1:0][31:0] io_scratch,
	output logic                         ej_trst_n
);

	ahb_req_t  bus_req;                             // Request of the owning master
	ahb_resp_t ram_resp;
	ahb_resp_t gpio_resp;
	logic      ram_sel;
	logic      gpio_sel;

	// ********************************************************
	// Masters side

	ahb_arbiter u_arbiter (
		.si_clk_in (si_clk_in),
		.arst_n    (arst_n),
		.busreq    (busreq),
		.bus_req   (bus_req),
		.hready    (resp.hready),
		.grant     (grant),
		.hmaster   (core_id)                        // Owner number is the core ID
	);

	ahb_master_mux u_master_mux (
		.si_clk_in (si_clk_in),
		.arst_n    (arst_n),
		.m0_req    (m0_req),
		.m1_req    (m1_req),
		.hmaster   (core_id),
		.hready    (resp.hready),
		.bus_req   (bus_req)
	);

	// ********************************************************
	// Slaves side

	ahb_slave_mux #(.RAM_WORDS(RAM_WORDS)) u_slave_mux (
		.si_clk_in (si_clk_in),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.ram_resp  (ram_resp),
		.gpio_resp (gpio_resp),
		.ram_sel   (ram_sel),
		.gpio_sel  (gpio_sel),
		.resp      (resp)
	);

	ahb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
		.si_clk_in (si_clk_in),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.ram_sel   (ram_sel),
		.hready    (resp.hready),
		.ram_resp  (ram_resp)
	);

	ahb_gpio u_gpio (
		.si_clk_in  (si_clk_in),
		.arst_n     (arst_n),
		.bus_req    (bus_req),
		.gpio_sel   (gpio_sel),
		.hready     (resp.hready),
		.io_switch  (io_switch),
		.io_pb      (io_pb),
		.gpio_resp  (gpio_resp),
		.io_ledr    (io_ledr),
		.io_ledg    (io_ledg),
		.io_scratch (io_scratch)
	);

	// EJTAG reset after power-up, merged with the probe
	ejtag_reset #(.TRST_CYCLES(TRST_CYCLES)) u_ejtag_reset (
		.si_clk_in       (si_clk_in),
		.arst_n          (arst_n),
		.ej_trst_n_probe (ej_trst_n_probe),
		.ej_trst_n       (ej_trst_n)
	);

endmodule

`default_nettype wire

// ==== tests/mipsfpga_sys_sva.sv ====
/*
 * Bound assertions for the AHB-Lite subsystem.
 * Grant movement, the ERROR response sequence and the EJTAG reset pulse.
 */
`default_nettype none

module mipsfpga_sys_sva import mipsfpga_pkg::*; #(
	parameter int TRST_CYCLES = 16
) (
	input wire            si_clk_in,
	input wire            arst_n,
	input wire [1:0]      grant,
	input wire htrans_t   bus_htrans,               // Transfer type of the owner
	input wire ahb_resp_t resp,
	input wire            ej_trst_n,
	input wire            ej_trst_n_probe
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;                             // Failed assertions so far

	// ********************************************************
	// Bus rules

	// Ownership moves only on an idle edge with hready high
	grant_moves_when_idle: assert property (@(posedge si_clk_in) disable iff (!arst_n)
		!(resp.hready && bus_htrans == IDLE) |=> $stable(grant))
		else begin
			fail_count++;
			$error("Grant moved while the bus was busy or stalled");
		end

	// A completing ERROR cycle always follows its wait state
	error_after_wait: assert property (@(posedge si_clk_in) disable iff (!arst_n)
		resp.hready && resp.hresp |-> $past(!resp.hready))
		else begin
			fail_count++;
			$error("ERROR response completed without a wait state");
		end

	error_two_cycles: assert property (@(posedge si_clk_in) disable iff (!arst_n)
		!resp.hready |=> resp.hready && resp.hresp)
		else begin
			fail_count++;
			$error("ERROR response did not complete in its second cycle");
		end

	// ********************************************************
	// EJTAG reset

	reset_pulse: assert property (@(posedge si_clk_in)
		$rose(arst_n) |-> !ej_trst_n [*TRST_CYCLES] ##1 (ej_trst_n || !ej_trst_n_probe))
		else begin
			fail_count++;
			$error("EJTAG reset pulse has the wrong length");
		end

	// Once released the counter stays saturated
	probe_after_release: assert property (@(posedge si_clk_in) disable iff (!arst_n)
		$past(ej_trst_n) |-> (ej_trst_n == ej_trst_n_probe))
		else begin
			fail_count++;
			$error("EJTAG reset does not follow the probe after release");
		end

endmodule

`default_nettype wire

// ==== tests/mipsfpga_sys_tb.sv ====
/*
 * Directed testbench for the dual-master AHB-Lite subsystem.
 * Plays both bus masters and checks RAM, I/O registers, arbitration,
 * unmapped-address ERROR and the EJTAG reset pulse.
 */
`default_nettype none

module mipsfpga_sys_tb import mipsfpga_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RAM_WORDS   = 256;               // 1 KiB covers all test addresses
	localparam int TRST_CYCLES = 16;
	localparam int NUM_XFERS   = 64;                // Bus transfers over all tests
	localparam int XFER_CYCLES = 4;                 // Grant wait, address and data phase
	localparam int MAX_CYCLES  = 4 + 2 * TRST_CYCLES + NUM_XFERS * XFER_CYCLES + 100;

	logic                         clk;
	logic                         arst_n;
	ahb_req_t                     mreq [2];         // Bus port of each master
	logic [1:0]                   busreq;
	logic [SW_W-1:0]              io_switch;
	logic [PB_W-1:0]              io_pb;
	logic                         ej_trst_n_probe;
	logic [1:0]                   grant;
	ahb_resp_t                    resp;
	logic [1:0]                   core_id;
	logic [LEDR_W-1:0]            io_ledr;
	logic [LEDG_W-1:0]            io_ledg;
	logic [NUM_SCRATCH-1:0][31:0] io_scratch;
	logic                         ej_trst_n;

	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] xfer_rdata;                        // Results of the last transfer
	int          xfer_waits;
	logic        xfer_first_hresp;                  // hresp in the first data cycle
	logic        xfer_hresp;

	mipsfpga_sys #(.RAM_WORDS(RAM_WORDS), .TRST_CYCLES(TRST_CYCLES)) DUT (
		.si_clk_in       (clk),
		.arst_n          (arst_n),
		.m0_req          (mreq[0]),
		.m1_req          (mreq[1]),
		.busreq          (busreq),
		.io_switch       (io_switch),
		.io_pb           (io_pb),
		.ej_trst_n_probe (ej_trst_n_probe),
		.grant           (grant),
		.resp            (resp),
		.core_id         (core_id),
		.io_ledr         (io_ledr),
		.io_ledg         (io_ledg),
		.io_scratch      (io_scratch),
		.ej_trst_n       (ej_trst_n)
	);

	bind mipsfpga_sys mipsfpga_sys_sva #(.TRST_CYCLES(TRST_CYCLES)) u_sva (
		.si_clk_in       (si_clk_in),
		.arst_n          (arst_n),
		.grant           (grant),
		.bus_htrans      (bus_req.htrans),
		.resp            (resp),
		.ej_trst_n       (ej_trst_n),
		.ej_trst_n_probe (ej_trst_n_probe)
	);

	always #10 clk = ~clk;                          // 20 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, the tests did not finish within %0d clock cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ********************************************************
	// Helpers

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] random_bits(input int nbits);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val        = {val[30:0], fb};
		end
		return val;
	endfunction

	// Expected word after a big-endian lane write
	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [1:0] ofs,
			input hsize_t size, input logic [31:0] data);
		logic [31:0] mask;
		case (size)
			BYTE:    mask = 32'hFF00_0000 >> (8 * ofs);          // Offset 0 is bits 31:24
			HALF:    mask = ofs[1] ? 32'h0000_FFFF : 32'hFFFF_0000;
			default: mask = 32'hFFFF_FFFF;
		endcase
		return (old & ~mask) | (data & mask);
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One single transfer entered and left on a falling edge
	task automatic run_transfer(input int m, input logic wr, input logic [31:0] addr,
			input hsize_t size, input logic [31:0] wdata);
		busreq[m] = 1'b1;
		while (!grant[m]) @(negedge clk);           // Wait for the bus
		mreq[m].haddr  = addr;
		mreq[m].htrans = NONSEQ;
		mreq[m].hwrite = wr;
		mreq[m].hsize  = size;
		while (!resp.hready) @(negedge clk);        // Held while a data phase stalls
		@(negedge clk);                             // Accepted so the data phase runs now
		mreq[m].htrans   = IDLE;
		mreq[m].hwdata   = wdata;
		xfer_waits       = 0;
		xfer_first_hresp = resp.hresp;
		while (!resp.hready) begin
			xfer_waits++;
			@(negedge clk);
		end
		xfer_rdata = resp.hrdata;
		xfer_hresp = resp.hresp;
		@(negedge clk);                             // Data phase ends on this edge
	endtask

	task automatic store(input int m, input logic [31:0] addr, input hsize_t size,
			input logic [31:0] data);
		run_transfer(m, 1'b1, addr, size, data);
		compare(xfer_waits, 0, $sformatf("wait states, write at %h", addr));
		compare(xfer_hresp, 0, $sformatf("response, write at %h", addr));
	endtask

	task automatic load(input int m, input logic [31:0] addr, output logic [31:0] data);
		run_transfer(m, 1'b0, addr, WORD, 32'h0);
		compare(xfer_waits, 0, $sformatf("wait states, read at %h", addr));
		compare(xfer_hresp, 0, $sformatf("response, read at %h", addr));
		data = xfer_rdata;
	endtask

	// ********************************************************
	// Tests

	task automatic ejtag_reset_pulse();
		int low_edges;
		low_edges = 0;
		while (!ej_trst_n && low_edges <= TRST_CYCLES) begin
			@(negedge clk);
			low_edges++;                            // Rising edges seen with reset low
		end
		compare(low_edges, TRST_CYCLES, "EJTAG reset edges after power-up");
		ej_trst_n_probe = 1'b0;
		@(negedge clk);
		compare(ej_trst_n, 1'b0, "EJTAG reset with the probe low");
		ej_trst_n_probe = 1'b1;
		@(negedge clk);
		compare(ej_trst_n, 1'b1, "EJTAG reset after the probe releases");
	endtask

	task automatic ram_word_access();
		logic [31:0] addr [6];
		logic [31:0] data [6];
		logic [31:0] rd;
		for (int i = 0; i < 6; i++) begin
			addr[i] = (i << 7) | (random_bits(5) << 2);   // Distinct words
			data[i] = random_bits(32);
			store(0, RAM_BASE + addr[i], WORD, data[i]);
		end
		for (int i = 0; i < 6; i++) begin
			load(0, RAM_BASE + addr[i], rd);
			compare(rd, data[i], $sformatf("RAM word at %h", addr[i]));
		end
	endtask

	task automatic ram_lane_writes();
		logic [31:0] addr;
		logic [31:0] model;                         // Expected word
		logic [31:0] data;
		logic [31:0] rd;
		addr  = RAM_BASE + 32'h0000_0380;
		model = random_bits(32);
		store(0, addr, WORD, model);
		for (int k = 0; k < 6; k++) begin
			data = random_bits(32);                 // Full word of which only the lane may land
			if (k < 4) begin
				store(0, addr + k, BYTE, data);
				model = merge_lanes(model, 2'(k), BYTE, data);
			end else begin
				store(0, addr + 2 * (k - 4), HALF, data);
				model = merge_lanes(model, 2'(2 * (k - 4)), HALF, data);
			end
			load(0, addr, rd);
			compare(rd, model, $sformatf("merged word after lane write %0d", k));
		end
	endtask

	task automatic gpio_registers();
		logic [31:0]     data;
		logic [31:0]     rd;
		logic [SW_W-1:0] sw;
		logic [PB_W-1:0] pb;
		data = random_bits(32);
		store(0, GPIO_BASE + LEDR_OFS, WORD, data);
		compare(io_ledr, data[LEDR_W-1:0], "red LEDs");
		data = random_bits(32);
		store(0, GPIO_BASE + LEDG_OFS, WORD, data);
		compare(io_ledg, data[LEDG_W-1:0], "green LEDs");
		load(0, GPIO_BASE + LEDG_OFS, rd);
		compare(rd, data[LEDG_W-1:0], "green LEDs read back");
		for (int i = 0; i < NUM_SCRATCH; i++) begin
			data = random_bits(32);
			store(0, GPIO_BASE + SCRATCH_OFS + 4 * i, WORD, data);
			compare(io_scratch[i], data, $sformatf("scratch %0d output", i));
			load(0, GPIO_BASE + SCRATCH_OFS + 4 * i, rd);
			compare(rd, data, $sformatf("scratch %0d read back", i));
		end
		load(0, GPIO_BASE + 32'h10, rd);
		compare(rd, 32'h0, "unknown I/O offset");
		sw        = random_bits(SW_W);
		pb        = random_bits(PB_W);
		io_switch = sw;
		io_pb     = pb;
		repeat (3) @(negedge clk);                  // Two-flop synchronizer delay
		load(0, GPIO_BASE + SWITCH_OFS, rd);
		compare(rd, 32'(sw), "switches");
		load(0, GPIO_BASE + PB_OFS, rd);
		compare(rd, 32'(pb), "push buttons");
		store(0, GPIO_BASE + SWITCH_OFS, WORD, ~32'(sw));   // Read only register
		load(0, GPIO_BASE + SWITCH_OFS, rd);
		compare(rd, 32'(sw), "switches after a write");
	endtask

	task automatic round_robin_grants();
		logic        owner;
		logic [31:0] rd;
		logic [31:0] data [2][3];
		busreq = 2'b11;
		owner  = 1'b0;                              // Only m0 has requested since reset
		repeat (4) begin
			@(negedge clk);
			owner = ~owner;                         // Both idle so every edge hands over
			compare(core_id, {1'b0, owner}, "core ID under round robin");
			compare(grant, owner ? 2'b10 : 2'b01, "grant under round robin");
		end
		for (int i = 0; i < 3; i++) begin
			for (int m = 0; m < 2; m++) begin
				data[m][i] = random_bits(32);
				store(m, 32'h0000_0100 * (m + 1) + 4 * i, WORD, data[m][i]);
			end
		end
		for (int i = 0; i < 3; i++) begin
			for (int m = 0; m < 2; m++) begin
				load(1 - m, 32'h0000_0100 * (m + 1) + 4 * i, rd);  // Through the other master
				compare(rd, data[m][i], $sformatf("write of master %0d, word %0d", m, i));
			end
		end
		busreq = 2'b01;
	endtask

	task automatic unmapped_access();
		logic [31:0] data;
		logic [31:0] rd;
		run_transfer(0, 1'b0, 32'h4000_0000, WORD, 32'h0);
		compare(xfer_waits, 1, "wait states on an unmapped read");
		compare(xfer_first_hresp, 1'b1, "response in the ERROR wait state");
		compare(xfer_hresp, 1'b1, "response when the ERROR completes");
		data = random_bits(32);
		store(0, RAM_BASE + 32'h0000_0040, WORD, data);
		load(0, RAM_BASE + 32'h0000_0040, rd);
		compare(rd, data, "RAM word after an ERROR");
	endtask

	// ********************************************************
	// Main sequence

	initial begin
		clk             = 1'b0;
		arst_n          = 1'b0;
		mreq[0]         = '0;                       // Both masters idle
		mreq[1]         = '0;
		busreq          = 2'b01;
		io_switch       = '0;
		io_pb           = '0;
		ej_trst_n_probe = 1'b1;
		lfsr_state      = 32'h8803_1c83;
		errors          = 0;
		checks          = 0;
		cycles          = 0;
		repeat (2) @(negedge clk);                  // Two reset cycles
		arst_n = 1'b1;
		ejtag_reset_pulse();
		ram_word_access();
		ram_lane_writes();
		gpio_registers();
		round_robin_grants();
		unmapped_access();
		repeat (2) @(negedge clk);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, DUT.u_sva.fail_count);
		if (errors == 0 && DUT.u_sva.fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/mipsfpga_pkg.sv
hdl/ejtag_reset.sv
hdl/ahb_arbiter.sv
hdl/ahb_master_mux.sv
hdl/ahb_slave_mux.sv
hdl/ahb_ram.sv
hdl/ahb_gpio.sv
hdl/mipsfpga_sys.sv
tests/mipsfpga_sys_sva.sv
tests/mipsfpga_sys_tb.sv
